//--- project.f
rtl/fq_pkg.sv
rtl/fq_sdp_ram.sv
rtl/fq_sync_fifo.sv
rtl/fq_checkpoint_regs.sv
rtl/fq_top.sv
tests/fq_props.sv
tests/tb_fq.sv

//--- Makefile
# Verilator build and run of the fetch queue testbench

TOP := tb_fq

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- tests/tb_fq.sv
// Fetch queue testbench
// Directed tests against a queue model and a kept-count model

`timescale 1ns/1ps
`default_nettype none

module tb_fq;

  logic clk;
  logic s_rst_n;
  logic push_i;
  logic pop_i;
  logic save_i;
  logic restore_i;
  logic flush_i;
  logic empty_o;
  logic full_o;
  logic ckpt_valid_o;
  logic [fq_pkg::FQ_CNT_W-1:0] cnt_o;
  fq_pkg::fq_entry_t push_data_i;
  fq_pkg::fq_entry_t head_data_o;

  // Reference models
  fq_pkg::fq_entry_t model_q[$];
  int  kept_m;
  bit  ckpt_m;
  logic [31:0] lfsr_q = 32'h5a8c;
  int  val_errs;
  int  to_errs;

  fq_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ====================
  // Stimulus helpers
  // ====================
  // Taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      w = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  task automatic check_entry(input string name, input fq_pkg::fq_entry_t got,
                             input fq_pkg::fq_entry_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input logic [fq_pkg::FQ_CNT_W-1:0] got,
                           input logic [fq_pkg::FQ_CNT_W-1:0] exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Compare every output with the model
  task automatic compare_model();
    check_cnt("cnt_o", cnt_o, fq_pkg::FQ_CNT_W'(model_q.size()));
    check_flag("empty_o", empty_o, model_q.size() == 0);
    check_flag("full_o", full_o, model_q.size() == fq_pkg::FQ_DEPTH);
    check_flag("ckpt_valid_o", ckpt_valid_o, ckpt_m);
    if (model_q.size() > 0) begin
      check_entry("head_data_o", head_data_o, model_q[0]);
    end
  endtask

  // One clock of strobes, model updated for the same edge
  task automatic step(input logic push, input logic pop, input logic save,
                      input logic restore, input logic flush);
    fq_pkg::fq_entry_t ent;
    logic push_ok;
    logic pop_ok;
    ent = '0;
    if (push) begin
      ent.pc    = rand_word();
      ent.instr = rand_word();
    end
    push_i      = push;
    push_data_i = ent;
    pop_i       = pop;
    save_i      = save;
    restore_i   = restore;
    flush_i     = flush;
    push_ok = push && (model_q.size() < fq_pkg::FQ_DEPTH);
    pop_ok  = pop && (model_q.size() > 0);
    if (flush) begin
      model_q.delete();
      ckpt_m = 0;
      kept_m = 0;
    end else if (restore && ckpt_m) begin
      // Younger entries dropped, strobes ignored
      while (model_q.size() > kept_m) begin
        model_q.delete(model_q.size() - 1);
      end
      ckpt_m = 0;
    end else begin
      // Restore without a checkpoint has no effect
      if (save) begin
        ckpt_m = 1;
        kept_m = model_q.size() - int'(pop_ok);
      end else if (ckpt_m && pop_ok && kept_m > 0) begin
        kept_m--;
      end
      if (pop_ok) begin
        model_q.delete(0);
      end
      if (push_ok) begin
        model_q.push_back(ent);
      end
    end
    @(posedge clk);
    #2;
    {push_i, pop_i, save_i, restore_i, flush_i} = '0;
    compare_model();
  endtask

  task automatic fill_until_full();
    int n;
    n = 0;
    while (full_o !== 1'b1 && n < 2 * fq_pkg::FQ_DEPTH) begin
      step(1, 0, 0, 0, 0);
      n++;
    end
    if (full_o !== 1'b1) begin
      to_errs++;
      $display("Timeout: queue never reported full");
    end
  endtask

  task automatic drain_until_empty();
    int n;
    n = 0;
    while (empty_o !== 1'b1 && n < 2 * fq_pkg::FQ_DEPTH) begin
      step(0, 1, 0, 0, 0);
      n++;
    end
    if (empty_o !== 1'b1) begin
      to_errs++;
      $display("Timeout: queue never drained");
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic basic_order();
    compare_model();
    repeat (3) step(1, 0, 0, 0, 0);
    repeat (3) step(0, 1, 0, 0, 0);
  endtask

  task automatic fill_and_drain();
    fill_until_full();
    // Extra push is dropped
    step(1, 0, 0, 0, 0);
    check_cnt("cnt_o", cnt_o, 8);
    drain_until_empty();
    repeat (2) step(0, 1, 0, 0, 0);
  endtask

  task automatic paired_push_pop();
    repeat (3) step(1, 0, 0, 0, 0);
    // Ten pairs walk both pointers past the wrap
    repeat (10) step(1, 1, 0, 0, 0);
    drain_until_empty();
  endtask

  task automatic restore_rewind();
    fq_pkg::fq_entry_t second;
    repeat (2) step(1, 0, 0, 0, 0);
    second = model_q[1];
    step(0, 0, 1, 0, 0);
    repeat (3) step(1, 0, 0, 0, 0);
    step(0, 1, 0, 0, 0);
    step(0, 0, 0, 1, 0);
    check_cnt("cnt_o", cnt_o, 1);
    check_entry("head_data_o", head_data_o, second);
    repeat (2) step(1, 0, 0, 0, 0);
    drain_until_empty();
  endtask

  task automatic kept_saturation();
    step(1, 0, 0, 0, 0);
    step(0, 0, 1, 0, 0);
    repeat (2) step(1, 0, 0, 0, 0);
    repeat (2) step(0, 1, 0, 0, 0);
    step(0, 0, 0, 1, 0);
    check_flag("empty_o", empty_o, 1'b1);
    // Stray restore leaves the queue alone
    repeat (2) step(1, 0, 0, 0, 0);
    step(0, 0, 0, 1, 0);
    check_cnt("cnt_o", cnt_o, 2);
    drain_until_empty();
  endtask

  task automatic flush_queue();
    repeat (4) step(1, 0, 0, 0, 0);
    step(0, 0, 1, 0, 0);
    step(1, 0, 0, 0, 0);
    step(0, 0, 0, 0, 1);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("ckpt_valid_o", ckpt_valid_o, 1'b0);
    step(1, 0, 0, 0, 0);
    drain_until_empty();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    s_rst_n     = 1'b0;
    push_i      = 1'b0;
    push_data_i = '0;
    pop_i       = 1'b0;
    save_i      = 1'b0;
    restore_i   = 1'b0;
    flush_i     = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    s_rst_n = 1'b1;
    basic_order();
    fill_and_drain();
    paired_push_pop();
    restore_rewind();
    kept_saturation();
    flush_queue();
    $display("Errors: %0d value, %0d timeout, %0d assertion", val_errs, to_errs,
             i_dut.i_fifo.i_props.fail_cnt);
    if (val_errs + to_errs + i_dut.i_fifo.i_props.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/fq_props.sv
// Fetch queue FIFO properties
// Status consistency and push accounting, bound into the FIFO

`timescale 1ns/1ps
`default_nettype none

module fq_props #(
  parameter int unsigned DEPTH = 8
) (
  input logic                       clk,
  input logic                       s_rst_n,
  input logic                       push_i,
  input logic                       pop_i,
  input logic                       redir_valid_i,
  input logic                       empty_i,
  input logic                       full_i,
  input logic [$clog2(DEPTH+1)-1:0] cnt_i
);

  // Failed assertions so far, read by the testbench
  int fail_cnt;

  // ====================
  // Status
  // ====================
  a_full_empty: assert property (@(posedge clk) disable iff (!s_rst_n)
    !(full_i && empty_i))
    else begin
      fail_cnt++;
      $error("full and empty are high together");
    end

  a_cnt_bound: assert property (@(posedge clk) disable iff (!s_rst_n)
    cnt_i <= ($clog2(DEPTH+1))'(DEPTH))
    else begin
      fail_cnt++;
      $error("count is above the queue depth");
    end

  // ====================
  // Push accounting
  // ====================
  // Lone accepted push raises the count by one
  a_push_cnt: assert property (@(posedge clk) disable iff (!s_rst_n)
    push_i && !full_i && !pop_i && !redir_valid_i |=> cnt_i == $past(cnt_i) + 1'b1)
    else begin
      fail_cnt++;
      $error("accepted push did not raise the count");
    end

endmodule

bind fq_sync_fifo fq_props #(.DEPTH(DEPTH)) i_props (
  .clk           (clk),
  .s_rst_n       (s_rst_n),
  .push_i        (push_i),
  .pop_i         (pop_i),
  .redir_valid_i (redirect_i.valid),
  .empty_i       (empty_o),
  .full_i        (full_o),
  .cnt_i         (cnt_o)
);

`default_nettype wire

//--- rtl/fq_top.sv
// Instruction fetch queue top
// Fetch pushes entries, decode pops the oldest,
// and the checkpoint block rewinds the queue on a mispredict

`timescale 1ns/1ps
`default_nettype none

module fq_top (
  input  logic                        clk,
  input  logic                        s_rst_n,

  // Fetch side
  input  logic                        push_i,
  input  fq_pkg::fq_entry_t           push_data_i,

  // Decode side
  input  logic                        pop_i,
  output fq_pkg::fq_entry_t           head_data_o,
  output logic                        empty_o,
  output logic                        full_o,
  output logic [fq_pkg::FQ_CNT_W-1:0] cnt_o,

  // Branch control
  input  logic                        save_i,
  input  logic                        restore_i,
  input  logic                        flush_i,
  output logic                        ckpt_valid_o
);

  // ====================
  // Internal links
  // ====================
  // FIFO count and pops toward the checkpoint
  fq_pkg::fq_state_t    fifo_state;
  // Rewind request back into the FIFO
  fq_pkg::fq_redirect_t redirect;

  // ====================
  // Queue
  // ====================
  fq_sync_fifo #(
    .DEPTH (fq_pkg::FQ_DEPTH),
    .WIDTH ($bits(fq_pkg::fq_entry_t))
  ) i_fifo (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .push_i      (push_i),
    .push_data_i (push_data_i),
    .pop_i       (pop_i),
    .redirect_i  (redirect),
    .head_data_o (head_data_o),
    .empty_o     (empty_o),
    .full_o      (full_o),
    .cnt_o       (cnt_o),
    .state_o     (fifo_state)
  );

  // ====================
  // Checkpoint
  // ====================
  fq_checkpoint_regs i_ckpt (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .save_i       (save_i),
    .restore_i    (restore_i),
    .flush_i      (flush_i),
    .state_i      (fifo_state),
    .redirect_o   (redirect),
    .ckpt_valid_o (ckpt_valid_o)
  );

endmodule

`default_nettype wire

//--- rtl/fq_checkpoint_regs.sv
// Fetch queue checkpoint
// Records how many entries are older than a branch, counts them
// down as they retire, and rewinds or empties the FIFO on demand

`timescale 1ns/1ps
`default_nettype none

module fq_checkpoint_regs (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 save_i,
  input  logic                 restore_i,
  input  logic                 flush_i,
  input  fq_pkg::fq_state_t    state_i,
  output fq_pkg::fq_redirect_t redirect_o,
  output logic                 ckpt_valid_o
);

  // ====================
  // Checkpoint state
  // ====================
  logic                        ckpt_valid_q;
  logic [fq_pkg::FQ_CNT_W-1:0] kept_q;

  // Older entries at save time
  logic [fq_pkg::FQ_CNT_W-1:0] save_cnt;
  // Restore only counts with a live checkpoint
  logic                        restore_ok;

  // A pop in the save cycle already retires one older entry
  assign save_cnt   = state_i.cnt - fq_pkg::FQ_CNT_W'(state_i.pop_fire);
  assign restore_ok = restore_i && ckpt_valid_q;

  assign ckpt_valid_o = ckpt_valid_q;

  // ====================
  // Redirect
  // ====================
  // Flush beats restore
  always_comb begin
    redirect_o.valid = 1'b0;
    redirect_o.kept  = '0;
    if (flush_i) begin
      redirect_o.valid = 1'b1;
      redirect_o.kept  = '0;
    end else if (restore_ok) begin
      redirect_o.valid = 1'b1;
      redirect_o.kept  = kept_q;
    end
  end

  // ====================
  // Update
  // ====================
  // Priority is flush, restore, save, then pop countdown
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      ckpt_valid_q <= 1'b0;
      kept_q       <= '0;
    end else if (flush_i) begin
      ckpt_valid_q <= 1'b0;
      kept_q       <= '0;
    end else if (restore_ok) begin
      // Consumed on restore
      ckpt_valid_q <= 1'b0;
      kept_q       <= '0;
    end else if (save_i) begin
      ckpt_valid_q <= 1'b1;
      kept_q       <= save_cnt;
    end else if (ckpt_valid_q && state_i.pop_fire) begin
      // Saturate once every older entry is gone
      if (kept_q != '0) begin
        kept_q <= kept_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/fq_sync_fifo.sv
// Synchronous FIFO with redirectable pointers
// Circular buffer of head, tail and count around the entry RAM.
// A redirect rewinds the tail to head plus kept and overrides push and pop

`timescale 1ns/1ps
`default_nettype none

module fq_sync_fifo #(
  parameter int unsigned DEPTH = 8,
  parameter int unsigned WIDTH = 64
) (
  input  logic                          clk,
  input  logic                          s_rst_n,
  input  logic                          push_i,
  input  logic [WIDTH-1:0]              push_data_i,
  input  logic                          pop_i,
  input  fq_pkg::fq_redirect_t          redirect_i,
  output logic [WIDTH-1:0]              head_data_o,
  output logic                          empty_o,
  output logic                          full_o,
  output logic [$clog2(DEPTH+1)-1:0]    cnt_o,
  output fq_pkg::fq_state_t             state_o
);

  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W  = $clog2(DEPTH+1);

  // ====================
  // State
  // ====================
  logic [ADDR_W-1:0] head_q;
  logic [ADDR_W-1:0] head_d;
  logic [ADDR_W-1:0] tail_q;
  logic [ADDR_W-1:0] tail_d;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_d;

  // Accepted strobes
  logic              push_fire;
  logic              pop_fire;

  // Redirect target
  logic [CNT_W-1:0]  redir_kept;
  logic [CNT_W-1:0]  redir_sum;
  logic [ADDR_W-1:0] redir_tail;

  // Advance a pointer, wrapping at the last slot
  function automatic logic [ADDR_W-1:0] ptr_inc(input logic [ADDR_W-1:0] ptr);
    if (ptr == ADDR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ====================
  // Status
  // ====================
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign cnt_o   = cnt_q;

  // Strobes are dropped in a redirect cycle
  assign push_fire = push_i && !full_o && !redirect_i.valid;
  assign pop_fire  = pop_i && !empty_o && !redirect_i.valid;

  // Count and accepted pops for the checkpoint block
  assign state_o.cnt      = fq_pkg::FQ_CNT_W'(cnt_q);
  assign state_o.pop_fire = pop_fire;

  // ====================
  // Redirect target
  // ====================
  // head < DEPTH and kept <= DEPTH, so one subtraction wraps the sum
  assign redir_kept = CNT_W'(redirect_i.kept);
  assign redir_sum  = CNT_W'(head_q) + redir_kept;
  assign redir_tail = (redir_sum >= CNT_W'(DEPTH)) ? ADDR_W'(redir_sum - CNT_W'(DEPTH))
                                                   : ADDR_W'(redir_sum);

  // ====================
  // Next state
  // ====================
  always_comb begin
    head_d = head_q;
    tail_d = tail_q;
    cnt_d  = cnt_q;

    if (push_fire) begin
      tail_d = ptr_inc(tail_q);
    end
    if (pop_fire) begin
      head_d = ptr_inc(head_q);
    end

    // Push and pop together leave the count alone
    case ({push_fire, pop_fire})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase

    // Head stays, younger entries are dropped
    if (redirect_i.valid) begin
      tail_d = redir_tail;
      cnt_d  = redir_kept;
    end
  end

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
    end else begin
      head_q <= head_d;
      tail_q <= tail_d;
      cnt_q  <= cnt_d;
    end
  end

  // ====================
  // Entry memory
  // ====================
  fq_sdp_ram #(
    .DEPTH (DEPTH),
    .WIDTH (WIDTH)
  ) i_ram (
    .clk     (clk),
    .we_i    (push_fire),
    .waddr_i (tail_q),
    .wdata_i (push_data_i),
    .raddr_i (head_q),
    .rdata_o (head_data_o)
  );

endmodule

`default_nettype wire

//--- rtl/fq_sdp_ram.sv
// Fetch queue entry memory
// One synchronous write port and one asynchronous read port,
// so the entry at the read address is always on rdata_o

`timescale 1ns/1ps
`default_nettype none

module fq_sdp_ram #(
  parameter int unsigned DEPTH = 8,
  parameter int unsigned WIDTH = 64
) (
  input  logic                                         clk,
  input  logic                                         we_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] waddr_i,
  input  logic [WIDTH-1:0]                             wdata_i,
  input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] raddr_i,
  output logic [WIDTH-1:0]                             rdata_o
);

  // ====================
  // Storage
  // ====================
  // Contents only meaningful under the FIFO count
  logic [WIDTH-1:0] mem [DEPTH];

  // Write on the rising edge
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // ====================
  // Read
  // ====================
  // Combinational, head entry visible without a pop
  assign rdata_o = mem[raddr_i];

endmodule

`default_nettype wire

//--- rtl/fq_pkg.sv
// Fetch queue shared definitions
// Queue geometry, the fetch entry layout and the
// state and redirect bundles between FIFO and checkpoint

`default_nettype none

package fq_pkg;

  // ====================
  // Queue geometry
  // ====================
  localparam int unsigned FQ_DEPTH  = 8;
  localparam int unsigned FQ_ADDR_W = $clog2(FQ_DEPTH);
  // One extra bit so the count can reach a full queue
  localparam int unsigned FQ_CNT_W  = $clog2(FQ_DEPTH) + 1;

  // ====================
  // Bundles
  // ====================
  // One fetched instruction with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fq_entry_t;

  // FIFO status seen by the checkpoint block
  typedef struct packed {
    logic [FQ_CNT_W-1:0] cnt;
    logic                pop_fire;
  } fq_state_t;

  // Pointer override from the checkpoint block
  typedef struct packed {
    logic                valid;
    logic [FQ_CNT_W-1:0] kept;
  } fq_redirect_t;

endpackage

`default_nettype wire
